// ==== hw/csr_types_pkg.sv ====
package csr_types_pkg;

  localparam int CSR_DATA_W = 32;
  typedef logic [CSR_DATA_W-1:0] csr_data_t; // Register value or write mask

  localparam int CSR_ADDR_W = 14;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  localparam int CNT_W = 64;
  typedef logic [CNT_W-1:0] cnt_t;

  // Privilege level field width, shared by CRMD and PRMD
  localparam int PLV_W = 2;

  // CRMD fields as LSB positions
  localparam int CRMD_PLV  = 0;  // Bits 1..0
  localparam int CRMD_IE   = 2;
  localparam int CRMD_DA   = 3;
  localparam int CRMD_PG   = 4;
  localparam int CRMD_DATF = 5;  // Bits 6..5
  localparam int CRMD_DATM = 7;  // Bits 8..7

  // Bits at and above this read zero
  localparam int CRMD_USED_W = 9;

  // Direct address mode out of reset
  localparam csr_data_t CRMD_RESET = csr_data_t'(1) << CRMD_DA;

  // PRMD fields
  localparam int PRMD_PPLV = 0;  // Bits 1..0
  localparam int PRMD_PIE  = 2;

endpackage

// ==== hw/csr_map_pkg.sv ====
package csr_map_pkg;

  // Architectural CSR numbers
  localparam csr_types_pkg::csr_addr_t CSR_CRMD   = 14'h000;
  localparam csr_types_pkg::csr_addr_t CSR_PRMD   = 14'h001;
  localparam csr_types_pkg::csr_addr_t CSR_ESTAT  = 14'h005;
  localparam csr_types_pkg::csr_addr_t CSR_ERA    = 14'h006;
  localparam csr_types_pkg::csr_addr_t CSR_EENTRY = 14'h00C;
  localparam csr_types_pkg::csr_addr_t CSR_SAVE0  = 14'h030;  // SAVE n at 0x30+n
  localparam csr_types_pkg::csr_addr_t CSR_TID    = 14'h040;

  // Internal register index
  typedef logic [4:0] csr_idx_t;
  localparam int NUM_IDX = 2 ** $bits(csr_idx_t);

  localparam csr_idx_t IDX_CRMD   = 5'd0;
  localparam csr_idx_t IDX_PRMD   = 5'd1;
  localparam csr_idx_t IDX_ESTAT  = 5'd2;
  localparam csr_idx_t IDX_ERA    = 5'd3;
  localparam csr_idx_t IDX_EENTRY = 5'd4;
  localparam csr_idx_t IDX_TID    = 5'd5;
  localparam csr_idx_t IDX_SAVE0  = 5'd6;   // SAVE n at 6+n
  localparam csr_idx_t IDX_NONE   = 5'd31;  // Unimplemented address

  // Counter read select
  typedef logic [1:0] rdcnt_t;

  localparam rdcnt_t RDCNT_NONE  = 2'd0;
  localparam rdcnt_t RDCNT_VLOW  = 2'd1;
  localparam rdcnt_t RDCNT_VHIGH = 2'd2;
  localparam rdcnt_t RDCNT_ID    = 2'd3;

endpackage

// ==== hw/csr_wr_if.sv ====
`timescale 1ns/1ps

interface csr_wr_if;
  import csr_types_pkg::*;
  import csr_map_pkg::*;

  logic      we;       // Qualified write strobe
  csr_idx_t  idx;
  csr_data_t mask;
  csr_data_t data;
  logic      trap;
  csr_data_t trap_pc;
  logic      ertn;

  modport decode  (output we, idx, mask, data, trap, trap_pc, ertn);
  modport regfile (input  we, idx, mask, data, trap, trap_pc, ertn);

endinterface

// ==== hw/csr_decode.sv ====
`timescale 1ns/1ps

module csr_decode #(
  parameter int NUM_SAVE = 4
) (
  input  logic                      valid_i,
  input  logic                      commit_i,
  input  logic                      stall_i,
  input  logic                      csr_we_i,
  input  logic                      trap_i,
  input  logic                      ertn_i,
  input  csr_types_pkg::csr_addr_t  csr_w_addr_i,
  input  csr_types_pkg::csr_addr_t  csr_r_addr_i,
  input  csr_types_pkg::csr_data_t  csr_w_mask_i,
  input  csr_types_pkg::csr_data_t  csr_w_data_i,
  input  csr_types_pkg::csr_data_t  trap_pc_i,
  input  csr_map_pkg::rdcnt_t       rdcnt_i,
  csr_wr_if.decode                  wr,
  output csr_map_pkg::csr_idx_t     rd_idx_o,
  output csr_map_pkg::rdcnt_t       rd_cnt_o
);
  import csr_types_pkg::*;
  import csr_map_pkg::*;

  logic     qual;
  csr_idx_t w_idx;

  function automatic csr_idx_t addr_to_idx(input csr_addr_t addr);
    csr_idx_t idx;
    idx = IDX_NONE;
    case (addr)
      CSR_CRMD:   idx = IDX_CRMD;
      CSR_PRMD:   idx = IDX_PRMD;
      CSR_ESTAT:  idx = IDX_ESTAT;
      CSR_ERA:    idx = IDX_ERA;
      CSR_EENTRY: idx = IDX_EENTRY;
      CSR_TID:    idx = IDX_TID;
      default: begin
        // SAVE window, trimmed to the bank size
        if (addr >= CSR_SAVE0 && addr < CSR_SAVE0 + csr_addr_t'(NUM_SAVE)) begin
          idx = IDX_SAVE0 + csr_idx_t'(addr - CSR_SAVE0);
        end
      end
    endcase
    return idx;
  endfunction

  // Only committed, valid, unstalled instructions touch state
  assign qual = valid_i & commit_i & ~stall_i;

  assign w_idx      = addr_to_idx(csr_w_addr_i);
  assign wr.we      = qual & csr_we_i & (w_idx != IDX_NONE);
  assign wr.idx     = w_idx;
  assign wr.mask    = csr_w_mask_i;
  assign wr.data    = csr_w_data_i;
  assign wr.trap    = qual & trap_i;
  assign wr.trap_pc = trap_pc_i;
  assign wr.ertn    = qual & ertn_i;

  assign rd_idx_o = addr_to_idx(csr_r_addr_i);
  assign rd_cnt_o = rdcnt_i;

endmodule

// ==== hw/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile #(
  parameter int NUM_SAVE = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  csr_wr_if.regfile                wr,
  output csr_types_pkg::csr_data_t regs_o [csr_map_pkg::NUM_IDX]
);
  import csr_types_pkg::*;
  import csr_map_pkg::*;

  localparam csr_data_t CRMD_MASK = csr_data_t'((64'd1 << CRMD_USED_W) - 64'd1);

  csr_data_t crmd_q;
  csr_data_t prmd_q;
  csr_data_t estat_q;
  csr_data_t era_q;
  csr_data_t eentry_q;
  csr_data_t tid_q;
  csr_data_t save_q [NUM_SAVE];

  logic [NUM_IDX-1:0] hit;  // One-hot write select
  csr_data_t          wr_val;

  assign hit    = wr.we ? (NUM_IDX'(1) << wr.idx) : '0;
  // Old bits where mask is 0, new data where mask is 1
  assign wr_val = (regs_o[wr.idx] & ~wr.mask) | (wr.data & wr.mask);

  // Later assignments win: write over return over trap
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= CRMD_RESET;
    end else begin
      if (wr.trap) begin
        crmd_q[CRMD_PLV +: PLV_W] <= '0;
        crmd_q[CRMD_IE]           <= 1'b0;
      end
      if (wr.ertn) begin
        crmd_q[CRMD_PLV +: PLV_W] <= prmd_q[PRMD_PPLV +: PLV_W];
        crmd_q[CRMD_IE]           <= prmd_q[PRMD_PIE];
      end
      if (hit[IDX_CRMD]) begin
        crmd_q <= wr_val & CRMD_MASK;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prmd_q <= '0;
      era_q  <= '0;
    end else begin
      if (wr.trap) begin
        prmd_q[PRMD_PPLV +: PLV_W] <= crmd_q[CRMD_PLV +: PLV_W];
        prmd_q[PRMD_PIE]           <= crmd_q[CRMD_IE];
        era_q                      <= wr.trap_pc;
      end
      if (hit[IDX_PRMD]) prmd_q <= wr_val;
      if (hit[IDX_ERA])  era_q  <= wr_val;
    end
  end

  // Plain storage, written only through the CSR port
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      estat_q  <= '0;
      eentry_q <= '0;
      tid_q    <= '0;
      for (int s = 0; s < NUM_SAVE; s++) begin
        save_q[s] <= '0;
      end
    end else begin
      if (hit[IDX_ESTAT])  estat_q  <= wr_val;
      if (hit[IDX_EENTRY]) eentry_q <= wr_val;
      if (hit[IDX_TID])    tid_q    <= wr_val;
      for (int s = 0; s < NUM_SAVE; s++) begin
        if (hit[IDX_SAVE0 + s]) save_q[s] <= wr_val;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_IDX; i++) begin
      regs_o[i] = '0;  // Unused indices read zero
    end
    regs_o[IDX_CRMD]   = crmd_q;
    regs_o[IDX_PRMD]   = prmd_q;
    regs_o[IDX_ESTAT]  = estat_q;
    regs_o[IDX_ERA]    = era_q;
    regs_o[IDX_EENTRY] = eentry_q;
    regs_o[IDX_TID]    = tid_q;
    for (int s = 0; s < NUM_SAVE; s++) begin
      regs_o[IDX_SAVE0 + s] = save_q[s];
    end
  end

endmodule

// ==== hw/csr_read_port.sv ====
`timescale 1ns/1ps

module csr_read_port (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stall_i,
  input  csr_map_pkg::csr_idx_t    rd_idx_i,
  input  csr_map_pkg::rdcnt_t      rd_cnt_i,
  input  csr_types_pkg::csr_data_t regs_i [csr_map_pkg::NUM_IDX],
  output csr_types_pkg::csr_data_t csr_r_data_o
);
  import csr_types_pkg::*;
  import csr_map_pkg::*;

  cnt_t      cnt_q;
  csr_data_t rd_next;

  // Stable counter runs regardless of stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + cnt_t'(1);
    end
  end

  always_comb begin
    case (rd_cnt_i)
      RDCNT_VLOW:  rd_next = cnt_q[CSR_DATA_W-1:0];
      RDCNT_VHIGH: rd_next = cnt_q[CNT_W-1:CSR_DATA_W];
      RDCNT_ID:    rd_next = regs_i[IDX_TID];  // Counter ID is TID
      default: begin
        rd_next = (rd_idx_i == IDX_NONE) ? '0 : regs_i[rd_idx_i];
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_r_data_o <= '0;
    end else if (!stall_i) begin
      csr_r_data_o <= rd_next;  // Hold while stalled
    end
  end

endmodule

// ==== hw/la_csr_top.sv ====
`timescale 1ns/1ps

module la_csr_top #(
  parameter int NUM_SAVE = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_i,
  input  logic                     commit_i,
  input  logic                     stall_i,
  input  csr_types_pkg::csr_addr_t csr_r_addr_i,
  input  csr_map_pkg::rdcnt_t      rdcnt_i,
  input  logic                     csr_we_i,
  input  csr_types_pkg::csr_addr_t csr_w_addr_i,
  input  csr_types_pkg::csr_data_t csr_w_mask_i,
  input  csr_types_pkg::csr_data_t csr_w_data_i,
  input  logic                     trap_i,
  input  csr_types_pkg::csr_data_t trap_pc_i,
  input  logic                     ertn_i,
  output csr_types_pkg::csr_data_t csr_r_data_o
);
  import csr_types_pkg::*;
  import csr_map_pkg::*;

  csr_idx_t  rd_idx;
  rdcnt_t    rd_cnt;
  csr_data_t regs [NUM_IDX];

  csr_wr_if wr_if ();

  csr_decode #(
    .NUM_SAVE(NUM_SAVE)
  ) u_decode (
    .valid_i      (valid_i),
    .commit_i     (commit_i),
    .stall_i      (stall_i),
    .csr_we_i     (csr_we_i),
    .trap_i       (trap_i),
    .ertn_i       (ertn_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_r_addr_i (csr_r_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .trap_pc_i    (trap_pc_i),
    .rdcnt_i      (rdcnt_i),
    .wr           (wr_if.decode),
    .rd_idx_o     (rd_idx),
    .rd_cnt_o     (rd_cnt)
  );

  csr_regfile #(
    .NUM_SAVE(NUM_SAVE)
  ) u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (wr_if.regfile),
    .regs_o (regs)
  );

  csr_read_port u_read_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .rd_idx_i     (rd_idx),
    .rd_cnt_i     (rd_cnt),
    .regs_i       (regs),
    .csr_r_data_o (csr_r_data_o)
  );

endmodule

// ==== testbench/la_csr_asserts.sv ====
`timescale 1ns/1ps

module la_csr_asserts (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     stall_i,
  input csr_types_pkg::csr_data_t csr_r_data_o
);

  int fail_cnt = 0;  // Failed assertion count

  // Read data holds across a stalled cycle
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    $past(stall_i) && $past(rst_n) |-> $stable(csr_r_data_o))
    else begin
      $error("read data changed after a stalled cycle");
      fail_cnt++;
    end

  reset_clears: assert property (@(posedge clk)
    !$past(rst_n) && rst_n |-> csr_r_data_o == '0)
    else begin
      $error("read data not zero after reset");
      fail_cnt++;
    end

  known_out: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(csr_r_data_o))
    else begin
      $error("read data has unknown bits");
      fail_cnt++;
    end

endmodule

bind la_csr_top la_csr_asserts u_asserts (.*);

// ==== testbench/tb_la_csr.sv ====
`timescale 1ns/1ps

module tb_la_csr;

  localparam int NUM_SAVE = 4;
  localparam int K_GAP    = 8;  // Cycles between the two counter reads
  // Cycles per test, each with its trailing idle read
  localparam int LEN_RESET = 5;
  localparam int LEN_T1    = 11;
  localparam int LEN_T2    = 41;
  localparam int LEN_T3    = 9;
  localparam int LEN_T4    = 8;
  localparam int LEN_T5    = 15;
  localparam int LEN_T6    = 21;
  localparam int LIMIT     = LEN_RESET + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6
                             + 1 + 100;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        valid_i, commit_i, stall_i, csr_we_i, trap_i, ertn_i;
  logic [13:0] csr_r_addr_i, csr_w_addr_i;
  logic [1:0]  rdcnt_i;
  logic [31:0] csr_w_mask_i, csr_w_data_i, trap_pc_i, csr_r_data_o;

  // Slots: CRMD PRMD ESTAT ERA EENTRY TID SAVE0..3
  logic [13:0] kept_addr [10] = '{14'h000, 14'h001, 14'h005, 14'h006, 14'h00c, 14'h040,
                                  14'h030, 14'h031, 14'h032, 14'h033};
  logic [13:0] unmapped [5]   = '{14'h002, 14'h034, 14'h03f, 14'h041, 14'h3fff};
  logic [31:0] model [10];
  logic [63:0] cnt_model;
  logic [31:0] exp_out;
  logic [31:0] lcg_state = 32'hca7e5aa8;
  logic [31:0] obs [0:LIMIT+1];  // Output seen at each negedge
  logic [31:0] exp_q [$];
  int          due_q [$];
  string       name_q [$];
  string       test_name;
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errs = 0;

  la_csr_top #(.NUM_SAVE(NUM_SAVE)) DUT (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc++;
    if (!rst_n) cnt_model = '0;  // Counter runs from reset release
    else cnt_model = cnt_model + 64'd1;
  end

  always @(posedge clk) begin
    if (cyc >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  always @(negedge clk) begin
    obs[cyc] = csr_r_data_o;
    while (due_q.size() > 0 && due_q[0] <= cyc) begin
      checks++;
      assert (csr_r_data_o === exp_q[0]) else begin
        $display("** Error %s: expected %08h, actual %08h", name_q[0], exp_q[0], csr_r_data_o);
        errors++;
        test_errs++;
      end
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
      void'(name_q.pop_front());
    end
  end

  function logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function int slot_of(input logic [13:0] addr);
    for (int i = 0; i < 10; i++) begin
      if (kept_addr[i] == addr) return i;
    end
    return -1;
  endfunction

  // Expected read result from the model state before the edge
  function logic [31:0] ref_read(input logic [13:0] addr, input logic [1:0] rc);
    int s;
    s = slot_of(addr);
    case (rc)
      2'd1:    return cnt_model[31:0];
      2'd2:    return cnt_model[63:32];
      2'd3:    return model[5];  // Counter ID reads TID
      default: return (s < 0) ? 32'h0 : model[s];
    endcase
  endfunction

  task apply_model(input logic we, input logic [13:0] waddr, input logic [31:0] mask,
                   input logic [31:0] data, input logic trap, input logic [31:0] pc,
                   input logic ertn);
    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] old_s;
    int          s;
    crmd = model[0];
    prmd = model[1];
    s = slot_of(waddr);
    old_s = (s >= 0) ? model[s] : 32'h0;
    if (trap) begin
      model[1][2:0] = crmd[2:0];  // PPLV and PIE
      model[0][2:0] = 3'b000;
      model[3] = pc;
    end
    if (ertn) model[0][2:0] = prmd[2:0];
    if (we && s >= 0) begin
      model[s] = (old_s & ~mask) | (data & mask);
      if (s == 0) model[0] = model[0] & 32'h0000_01ff;  // CRMD bits 8..0 only
    end
  endtask

  task issue(input logic [13:0] raddr, input logic [1:0] rc, input logic we,
             input logic [13:0] waddr, input logic [31:0] mask, input logic [31:0] data,
             input logic trap, input logic [31:0] pc, input logic ertn, input logic stall);
    @(posedge clk);
    #2;
    {valid_i, commit_i, stall_i} = {2'b11, stall};
    {csr_r_addr_i, rdcnt_i} = {raddr, rc};
    {csr_we_i, csr_w_addr_i, csr_w_mask_i, csr_w_data_i} = {we, waddr, mask, data};
    {trap_i, trap_pc_i, ertn_i} = {trap, pc, ertn};
    if (!stall) exp_out = ref_read(raddr, rc);  // Held output otherwise
    exp_q.push_back(exp_out);
    due_q.push_back(cyc + 1);
    name_q.push_back(test_name);
    if (!stall) apply_model(we, waddr, mask, data, trap, pc, ertn);
  endtask

  task do_read(input logic [13:0] addr);
    issue(addr, 2'd0, 1'b0, 14'h0, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
  endtask

  // Reads the same address, so the old value comes back
  task do_write(input logic [13:0] addr, input logic [31:0] mask, input logic [31:0] data);
    issue(addr, 2'd0, 1'b1, addr, mask, data, 1'b0, 32'h0, 1'b0, 1'b0);
  endtask

  task start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task end_test();
    do_read(14'h000);
    @(negedge clk);
    #1;
    $display("Test %-14s done, %0d errors", test_name, test_errs);
  endtask

  initial begin
    int c1;
    int c2;
    rst_n = 1'b0;
    {valid_i, commit_i, stall_i, csr_we_i, trap_i, ertn_i} = '0;
    {csr_r_addr_i, csr_w_addr_i, rdcnt_i} = '0;
    {csr_w_mask_i, csr_w_data_i, trap_pc_i} = '0;
    model = '{default: 32'h0};
    model[0] = 32'h0000_0008;  // CRMD.DA
    exp_out = 32'h0;
    repeat (LEN_RESET) @(posedge clk);
    #2;
    rst_n = 1'b1;

    start_test("reset_values");
    for (int i = 0; i < 10; i++) do_read(kept_addr[i]);
    end_test();

    start_test("masked_writes");
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 10; i++) begin
        do_write(kept_addr[i], rand32(), rand32());
        do_read(kept_addr[i]);
      end
    end
    end_test();

    start_test("trap_return");
    do_write(14'h000, 32'h7, 32'h7);  // PLV 3, IE on
    issue(14'h000, 2'd0, 1'b0, 14'h0, 32'h0, 32'h0, 1'b1, rand32(), 1'b0, 1'b0);
    do_read(14'h001);
    do_read(14'h000);
    do_read(14'h006);
    issue(14'h001, 2'd0, 1'b0, 14'h0, 32'h0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0);
    issue(14'h000, 2'd0, 1'b1, 14'h000, 32'h7, 32'h2, 1'b0, 32'h0, 1'b1, 1'b0);
    do_read(14'h000);
    end_test();

    start_test("stall");
    do_read(14'h00c);
    issue(14'h001, 2'd0, 1'b1, 14'h00c, '1, rand32(), 1'b1, rand32(), 1'b0, 1'b1);
    issue(14'h006, 2'd0, 1'b1, 14'h000, '1, 32'h1ff, 1'b0, 32'h0, 1'b1, 1'b1);
    do_read(14'h00c);
    do_read(14'h006);
    do_read(14'h000);
    do_read(14'h001);
    end_test();

    start_test("counter");
    issue(14'h0, 2'd1, 1'b0, 14'h0, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
    c1 = cyc;
    for (int k = 1; k < K_GAP; k++) do_read(14'h040);
    issue(14'h0, 2'd1, 1'b0, 14'h0, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
    c2 = cyc;
    do_read(14'h000);
    do_read(14'h000);
    checks++;
    assert (obs[c2 + 1] - obs[c1 + 1] == K_GAP) else begin
      $display("** Error counter: expected delta %0d, actual %0d", K_GAP,
               obs[c2 + 1] - obs[c1 + 1]);
      errors++;
      test_errs++;
    end
    issue(14'h0, 2'd2, 1'b0, 14'h0, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
    do_write(14'h040, '1, rand32());
    issue(14'h0, 2'd3, 1'b0, 14'h0, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
    end_test();

    start_test("unmapped");
    for (int i = 0; i < 5; i++) begin
      do_write(unmapped[i], '1, rand32());
      do_read(unmapped[i]);
    end
    for (int i = 0; i < 10; i++) do_read(kept_addr[i]);
    end_test();

    @(negedge clk);
    #1;
    $display("Checks %0d, errors %0d, assertion failures %0d, unchecked %0d", checks, errors,
             DUT.u_asserts.fail_cnt, exp_q.size());
    if (errors == 0 && DUT.u_asserts.fail_cnt == 0 && exp_q.size() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hw/csr_types_pkg.sv
hw/csr_map_pkg.sv
hw/csr_wr_if.sv
hw/csr_decode.sv
hw/csr_regfile.sv
hw/csr_read_port.sv
hw/la_csr_top.sv
testbench/la_csr_asserts.sv
testbench/tb_la_csr.sv

// ==== Bender.yml ====
package:
  name: la_csr

sources:
  - hw/csr_types_pkg.sv
  - hw/csr_map_pkg.sv
  - hw/csr_wr_if.sv
  - hw/csr_decode.sv
  - hw/csr_regfile.sv
  - hw/csr_read_port.sv
  - hw/la_csr_top.sv
  - target: test
    files:
      - testbench/la_csr_asserts.sv
      - testbench/tb_la_csr.sv
